/* common/memMap_defs.svh */
// Address map of the data bus; region ends are exclusive and timer windows must not overlap
`ifndef MEMMAP_DEFS_SVH
`define MEMMAP_DEFS_SVH

// Data memory region
`define DM_ADDR_START       32'h0000_0000
`define DM_ADDR_END         32'h0000_3000
`define DM_DEPTH_WORDS      ((`DM_ADDR_END - `DM_ADDR_START) / 4)

// Timer windows, three registers each
`define TIMER0_ADDR_START   32'h0000_7F00
`define TIMER0_ADDR_END     32'h0000_7F0C
`define TIMER1_ADDR_START   32'h0000_7F10
`define TIMER1_ADDR_END     32'h0000_7F1C

// Whole device region seen by the north bridge, gap included
`define DEV_ADDR_START      32'h0000_7F00
`define DEV_ADDR_END        32'h0000_7F1C

// Byte offsets inside one timer window
`define TIMER_REG_CTRL      32'h0000_0000
`define TIMER_REG_PRESET    32'h0000_0004
`define TIMER_REG_COUNT     32'h0000_0008

// Timer modes, anything else behaves as one-shot
`define TIMER_MODE_ONESHOT  2'd0
`define TIMER_MODE_RELOAD   2'd1

`endif

/* common/busPkg.sv */
// Bus and timer types; byte enables exist only on the CPU side, devices see full-word writes
package busPkg;

    // One CPU-side data access, we holds one bit per byte lane
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  we;
    } busReq;

    // Full-word device access behind the south bridge
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } devReq;

    // Timer control register, bit 0 is enable
    typedef struct packed {
        logic       irqMask;
        logic [1:0] mode;
        logic       enable;
    } timerCtrl;

    // Register bank of one timer
    typedef struct packed {
        timerCtrl    ctrl;
        logic [31:0] preset;
        logic [31:0] count;
    } timerRegs;

    // Hardware interrupt lines as the CPU numbers them
    typedef logic [7:2] hwIntVec;

endpackage

/* hw/timer/timer.sv */
// Countdown timer with CTRL/PRESET/COUNT; full-word writes only, COUNT is read-only
`timescale 1ns/1ps
`include "memMap_defs.svh"

module timer (
    input  logic          clk,
    input  logic          rst,
    input  busPkg::devReq req,
    output logic [31:0]   rdata,
    output logic          irq
);
    import busPkg::*;

    timerRegs    regs;
    logic        reloadPending;
    logic [31:0] regOff;
    logic        wrCtrl;
    logic        wrPreset;
    logic        isReload;
    logic        expire;

    // Word-aligned register offset
    assign regOff   = {req.addr[31:2], 2'b00};
    assign wrCtrl   = req.we && (regOff == `TIMER_REG_CTRL);
    assign wrPreset = req.we && (regOff == `TIMER_REG_PRESET);

    assign isReload = (regs.ctrl.mode == `TIMER_MODE_RELOAD);

    // Count is about to go from 1 to 0
    assign expire = regs.ctrl.enable && (regs.count == 32'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs          <= '0;
            reloadPending <= 1'b0;
            irq           <= 1'b0;
        end else begin
            // Countdown, reload one cycle after reaching zero
            if (reloadPending) begin
                regs.count    <= regs.preset;
                reloadPending <= 1'b0;
            end else if (regs.ctrl.enable && (regs.count != 32'd0)) begin
                regs.count <= regs.count - 32'd1;
            end

            if (expire) begin
                if (isReload) begin
                    reloadPending <= 1'b1;
                end else begin
                    regs.ctrl.enable <= 1'b0;
                end
            end

            // Sticky irq, cleared by any CTRL write
            if (wrCtrl) begin
                irq <= 1'b0;
            end
            if (expire && regs.ctrl.irqMask) begin
                irq <= 1'b1;
            end

            // Bus writes override the countdown
            if (wrCtrl) begin
                regs.ctrl <= timerCtrl'(req.wdata[3:0]);
            end
            if (wrPreset) begin
                regs.preset   <= req.wdata;
                regs.count    <= req.wdata;
                reloadPending <= 1'b0;
            end
        end
    end

    always_comb begin
        case (regOff)
            `TIMER_REG_CTRL:   rdata = {28'd0, regs.ctrl};
            `TIMER_REG_PRESET: rdata = regs.preset;
            `TIMER_REG_COUNT:  rdata = regs.count;
            default:           rdata = 32'd0;
        endcase
    end

    // South bridge hands over aligned offsets of existing registers only
    assert property (@(posedge clk) disable iff (rst)
        req.we |-> (req.addr inside {`TIMER_REG_CTRL, `TIMER_REG_PRESET, `TIMER_REG_COUNT}))
        else $error("timer: write to bad offset 0x%08h", req.addr);

endmodule

/* hw/dataMemory/dataMemory.sv */
// Word memory with byte-lane writes and asynchronous read; contents are not cleared by reset
`timescale 1ns/1ps

module dataMemory #(
    parameter int depthWords = 3072
) (
    input  logic          clk,
    input  busPkg::busReq req,
    output logic [31:0]   rdata
);
    localparam int idxWidth = $clog2(depthWords);

    logic [31:0]         mem [depthWords];
    logic [29:0]         wordAddr;
    logic [idxWidth-1:0] wordIdx;

    assign wordAddr = req.addr[31:2];
    assign wordIdx  = wordAddr[idxWidth-1:0];

    // Each enabled lane overwrites its byte, the rest keep old data
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (req.we[lane]) begin
                mem[wordIdx][8*lane +: 8] <= req.wdata[8*lane +: 8];
            end
        end
    end

    // Outside the array reads as zero
    assign rdata = (wordAddr < 30'(depthWords)) ? mem[wordIdx] : 32'd0;

    // Bridge must keep writes inside the array
    assert property (@(posedge clk) (|req.we) |-> (wordAddr < 30'(depthWords)))
        else $error("dataMemory: write to word %0d beyond depth %0d", wordAddr, depthWords);

endmodule

/* hw/bridge/northBridge.sv */
// Top-level decode of the CPU data port; device writes need all four byte enables
`timescale 1ns/1ps
`include "memMap_defs.svh"

module northBridge (
    input  busPkg::busReq cpuReq,
    output logic [31:0]   rdata,
    // Data memory side
    output busPkg::busReq dmReq,
    input  logic [31:0]   dmRdata,
    // South bridge side
    output busPkg::devReq devReq,
    input  logic [31:0]   devRdata
);
    logic inDm;
    logic inDev;

    // Region decode, memory range taken as an offset from its base
    assign inDm  = (cpuReq.addr - `DM_ADDR_START) < (`DM_ADDR_END - `DM_ADDR_START);
    assign inDev = (cpuReq.addr >= `DEV_ADDR_START) && (cpuReq.addr < `DEV_ADDR_END);

    // Memory keeps the byte lanes
    always_comb begin
        dmReq.addr  = cpuReq.addr;
        dmReq.wdata = cpuReq.wdata;
        dmReq.we    = inDm ? cpuReq.we : 4'b0000;
    end

    // Devices only take whole words
    always_comb begin
        devReq.addr  = cpuReq.addr;
        devReq.wdata = cpuReq.wdata;
        devReq.we    = inDev && (&cpuReq.we);
    end

    // Read data select, unmapped reads give zero
    always_comb begin
        if (inDm) begin
            rdata = dmRdata;
        end else if (inDev) begin
            rdata = devRdata;
        end else begin
            rdata = 32'd0;
        end
    end

    // A write lands in at most one region
    always_comb begin
        assert (!((|dmReq.we) && devReq.we))
            else $error("northBridge: write routed to memory and devices at once");
    end

endmodule

/* hw/bridge/southBridge.sv */
// Splits the device region between two timers; writes to the gap are dropped here
`timescale 1ns/1ps
`include "memMap_defs.svh"

module southBridge (
    input  busPkg::devReq   hostReq,
    output logic [31:0]     rdata,
    // Timer 0
    output busPkg::devReq   timer0Req,
    input  logic [31:0]     timer0Rdata,
    input  logic            timer0Irq,
    // Timer 1
    output busPkg::devReq   timer1Req,
    input  logic [31:0]     timer1Rdata,
    input  logic            timer1Irq,
    // Interrupts
    input  logic            extInt,
    output busPkg::hwIntVec hwInt
);
    logic inTimer0;
    logic inTimer1;

    assign inTimer0 = (hostReq.addr >= `TIMER0_ADDR_START) && (hostReq.addr < `TIMER0_ADDR_END);
    assign inTimer1 = (hostReq.addr >= `TIMER1_ADDR_START) && (hostReq.addr < `TIMER1_ADDR_END);

    // Timers see an offset relative to their window
    always_comb begin
        timer0Req.addr  = hostReq.addr - `TIMER0_ADDR_START;
        timer0Req.wdata = hostReq.wdata;
        timer0Req.we    = hostReq.we && inTimer0;
    end

    always_comb begin
        timer1Req.addr  = hostReq.addr - `TIMER1_ADDR_START;
        timer1Req.wdata = hostReq.wdata;
        timer1Req.we    = hostReq.we && inTimer1;
    end

    always_comb begin
        if (inTimer0) begin
            rdata = timer0Rdata;
        end else if (inTimer1) begin
            rdata = timer1Rdata;
        end else begin
            rdata = 32'd0;
        end
    end

    // Bits 7..5 unused
    assign hwInt = {3'b000, extInt, timer1Irq, timer0Irq};

    // Only one timer is written, and its rewritten offset stays inside its own window
    always_comb begin
        assert (!(timer0Req.we && timer1Req.we) &&
                (!timer0Req.we ||
                 (timer0Req.addr < (`TIMER0_ADDR_END - `TIMER0_ADDR_START))) &&
                (!timer1Req.we ||
                 (timer1Req.addr < (`TIMER1_ADDR_END - `TIMER1_ADDR_START))))
            else $error("southBridge: timer write outside the timer windows");
    end

endmodule

/* hw/busSystem.sv */
// Data-side bus top: one CPU data port, data memory and two timers; no instruction port
`timescale 1ns/1ps
`include "memMap_defs.svh"

module busSystem (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     addr,
    input  logic [31:0]     wdata,
    input  logic [3:0]      we,
    input  logic            extInt,
    output logic [31:0]     rdata,
    output busPkg::hwIntVec hwInt
);
    import busPkg::*;

    busReq       cpuReq;
    busReq       dmReq;
    logic [31:0] dmRdata;
    devReq       devBusReq;
    logic [31:0] devRdata;
    devReq       timer0Req;
    logic [31:0] timer0Rdata;
    logic        timer0Irq;
    devReq       timer1Req;
    logic [31:0] timer1Rdata;
    logic        timer1Irq;

    assign cpuReq = '{addr: addr, wdata: wdata, we: we};

    northBridge u_northBridge (
        .cpuReq   (cpuReq),
        .rdata    (rdata),
        .dmReq    (dmReq),
        .dmRdata  (dmRdata),
        .devReq   (devBusReq),
        .devRdata (devRdata)
    );

    dataMemory #(
        .depthWords (`DM_DEPTH_WORDS)
    ) u_dataMemory (
        .clk   (clk),
        .req   (dmReq),
        .rdata (dmRdata)
    );

    southBridge u_southBridge (
        .hostReq     (devBusReq),
        .rdata       (devRdata),
        .timer0Req   (timer0Req),
        .timer0Rdata (timer0Rdata),
        .timer0Irq   (timer0Irq),
        .timer1Req   (timer1Req),
        .timer1Rdata (timer1Rdata),
        .timer1Irq   (timer1Irq),
        .extInt      (extInt),
        .hwInt       (hwInt)
    );

    timer u_timer0 (
        .clk   (clk),
        .rst   (rst),
        .req   (timer0Req),
        .rdata (timer0Rdata),
        .irq   (timer0Irq)
    );

    timer u_timer1 (
        .clk   (clk),
        .rst   (rst),
        .req   (timer1Req),
        .rdata (timer1Rdata),
        .irq   (timer1Irq)
    );

endmodule

/* tb/busSystemTb.sv */
// Testbench for the data bus; each table row takes one cycle, timer waits poll COUNT with a cycle limit
`timescale 1ns/1ps

module busSystemTb;
    import busPkg::*;

    localparam int opWrite    = 0;
    localparam int opRead     = 1;
    localparam int opWaitZero = 2;
    localparam int opIrq      = 3;
    localparam int opExt      = 4;
    localparam int opReload   = 5;
    localparam int pollLimit  = 64;

    logic        clk;
    logic        rst;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  we;
    logic        extInt;
    logic [31:0] rdata;
    hwIntVec     hwInt;

    logic        extLevel;
    logic [31:0] rnd [6];
    int          checkCount;
    int          errorCount;

    // Stimulus table
    string       names [$];
    int          ops   [$];
    logic [31:0] addrs [$];
    logic [31:0] datas [$];
    logic [3:0]  bes   [$];
    logic [31:0] exps  [$];

    busSystem u_busSystem (
        .clk    (clk),
        .rst    (rst),
        .addr   (addr),
        .wdata  (wdata),
        .we     (we),
        .extInt (extInt),
        .rdata  (rdata),
        .hwInt  (hwInt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0]  be);
        logic [31:0] result;
        result = oldWord;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                result[8*lane +: 8] = newWord[8*lane +: 8];
            end
        end
        return result;
    endfunction

    task automatic addRow(input string name, input int op, input logic [31:0] a,
                          input logic [31:0] d, input logic [3:0] be, input logic [31:0] e);
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(a);
        datas.push_back(d);
        bes.push_back(be);
        exps.push_back(e);
    endtask

    // One bus cycle, inputs change 1 ns after the edge and outputs settle before the next
    task automatic busCycle(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        @(posedge clk);
        #1;
        addr   = a;
        wdata  = d;
        we     = be;
        extInt = extLevel;
        #1;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end else begin
            $display("PASS %s: 0x%08h", name, actual);
        end
    endtask

    // Counts edges from the PRESET write until COUNT reads zero
    task automatic waitCountZero(input string name, input logic [31:0] a,
                                 input logic [31:0] expEdges);
        int  cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < pollLimit) begin
            busCycle(a, 32'd0, 4'b0000);
            cycles++;
            if (rdata == 32'd0) begin
                done = 1'b1;
            end
        end
        if (done) begin
            checkValue(name, expEdges, cycles - 1);
        end else begin
            errorCount++;
            $display("Timeout in %s: COUNT at 0x%08h did not reach zero in %0d cycles",
                     name, a, pollLimit);
        end
    endtask

    // After zero an auto-reload timer shows the preset again
    task automatic waitReload(input string name, input logic [31:0] a,
                              input logic [31:0] preset);
        int  cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < pollLimit) begin
            busCycle(a, 32'd0, 4'b0000);
            cycles++;
            if (rdata != 32'd0) begin
                done = 1'b1;
            end
        end
        if (done) begin
            checkValue(name, preset, rdata);
        end else begin
            errorCount++;
            $display("Timeout in %s: COUNT at 0x%08h stayed zero for %0d cycles",
                     name, a, pollLimit);
        end
    endtask

    task automatic applyRow(input int i);
        case (ops[i])
            opWrite: busCycle(addrs[i], datas[i], bes[i]);
            opRead: begin
                busCycle(addrs[i], 32'd0, 4'b0000);
                checkValue(names[i], exps[i], rdata);
            end
            opWaitZero: waitCountZero(names[i], addrs[i], exps[i]);
            opReload:   waitReload(names[i], addrs[i], exps[i]);
            opIrq: begin
                busCycle(addrs[i], 32'd0, 4'b0000);
                checkValue(names[i], exps[i], {24'd0, hwInt, 2'b00});
            end
            opExt: begin
                extLevel = datas[i][0];
                busCycle(addrs[i], 32'd0, 4'b0000);
                checkValue(names[i], exps[i], {24'd0, hwInt, 2'b00});
            end
            default: begin
                errorCount++;
                $display("Row %s has an unknown operation", names[i]);
            end
        endcase
    endtask

    initial begin
        rst        = 1'b1;
        addr       = 32'd0;
        wdata      = 32'd0;
        we         = 4'b0000;
        extInt     = 1'b0;
        extLevel   = 1'b0;
        checkCount = 0;
        errorCount = 0;
        void'($urandom(19));
        for (int k = 0; k < 6; k++) begin
            rnd[k] = $urandom();
        end

        // Data memory, full words and byte lanes
        addRow("dm word write", opWrite, 32'h100, rnd[0], 4'hF, 32'd0);
        addRow("dm word read", opRead, 32'h100, 32'd0, 4'h0, rnd[0]);
        addRow("dm byte1 write", opWrite, 32'h100, rnd[1], 4'h2, 32'd0);
        addRow("dm byte1 read", opRead, 32'h100, 32'd0, 4'h0, mergeBytes(rnd[0], rnd[1], 4'h2));
        addRow("dm top write", opWrite, 32'h2FFC, rnd[2], 4'hF, 32'd0);
        addRow("dm top lanes write", opWrite, 32'h2FFC, rnd[3], 4'h9, 32'd0);
        addRow("dm top lanes read", opRead, 32'h2FFC, 32'd0, 4'h0,
               mergeBytes(rnd[2], rnd[3], 4'h9));
        addRow("dm word0 write", opWrite, 32'h0, rnd[4], 4'hF, 32'd0);
        // Unmapped and gap accesses
        addRow("unmapped write", opWrite, 32'h4000, rnd[5], 4'hF, 32'd0);
        addRow("unmapped read", opRead, 32'h4000, 32'd0, 4'h0, 32'd0);
        addRow("dm word0 no alias", opRead, 32'h0, 32'd0, 4'h0, rnd[4]);
        addRow("gap write", opWrite, 32'h7F0C, rnd[5], 4'hF, 32'd0);
        addRow("gap read", opRead, 32'h7F0C, 32'd0, 4'h0, 32'd0);
        addRow("past devices read", opRead, 32'h7F1C, 32'd0, 4'h0, 32'd0);
        addRow("timer0 half write", opWrite, 32'h7F04, 32'h1234, 4'h3, 32'd0);
        addRow("timer0 half ignored", opRead, 32'h7F04, 32'd0, 4'h0, 32'd0);
        addRow("timer0 count write", opWrite, 32'h7F08, 32'h55, 4'hF, 32'd0);
        addRow("timer0 count ignored", opRead, 32'h7F08, 32'd0, 4'h0, 32'd0);
        // Timer0 one-shot with interrupt
        addRow("timer0 ctrl write", opWrite, 32'h7F00, 32'h9, 4'hF, 32'd0);
        addRow("timer0 preset write", opWrite, 32'h7F04, 32'd5, 4'hF, 32'd0);
        addRow("timer0 count zero", opWaitZero, 32'h7F08, 32'd0, 4'h0, 32'd5);
        addRow("timer0 enable cleared", opRead, 32'h7F00, 32'd0, 4'h0, 32'h8);
        addRow("timer0 irq set", opIrq, 32'd0, 32'd0, 4'h0, 32'h04);
        addRow("timer0 irq clear write", opWrite, 32'h7F00, 32'h0, 4'hF, 32'd0);
        addRow("timer0 irq cleared", opIrq, 32'd0, 32'd0, 4'h0, 32'h00);
        // Timer1 with interrupt masked
        addRow("timer1 ctrl write", opWrite, 32'h7F10, 32'h1, 4'hF, 32'd0);
        addRow("timer1 preset write", opWrite, 32'h7F14, 32'd3, 4'hF, 32'd0);
        addRow("timer1 count zero", opWaitZero, 32'h7F18, 32'd0, 4'h0, 32'd3);
        addRow("timer1 enable cleared", opRead, 32'h7F10, 32'd0, 4'h0, 32'h0);
        addRow("timer1 irq masked", opIrq, 32'd0, 32'd0, 4'h0, 32'h00);
        // Timer1 auto-reload
        addRow("timer1 reload ctrl", opWrite, 32'h7F10, 32'h3, 4'hF, 32'd0);
        addRow("timer1 reload preset", opWrite, 32'h7F14, 32'd4, 4'hF, 32'd0);
        addRow("timer1 reload zero", opWaitZero, 32'h7F18, 32'd0, 4'h0, 32'd4);
        addRow("timer1 reloaded", opReload, 32'h7F18, 32'd0, 4'h0, 32'd4);
        addRow("timer1 reload no irq", opIrq, 32'd0, 32'd0, 4'h0, 32'h00);
        addRow("timer1 stop", opWrite, 32'h7F10, 32'h0, 4'hF, 32'd0);
        // External interrupt on bit 4
        addRow("ext irq high", opExt, 32'd0, 32'd1, 4'h0, 32'h10);
        addRow("ext irq low", opExt, 32'd0, 32'd0, 4'h0, 32'h00);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < names.size(); i++) begin
            applyRow(i);
        end

        $display("Checks run: %0d, failures: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/busPkg.sv
hw/timer/timer.sv
hw/dataMemory/dataMemory.sv
hw/bridge/northBridge.sv
hw/bridge/southBridge.sv
hw/busSystem.sv
tb/busSystemTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module busSystemTb \
    --Mdir obj_dir -o busSystemTb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/busSystemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
